//--- files.f
+incdir+.
axi3_slice_pkg.sv
axi_channel_slice.sv
reset_pipe.sv
axi3_reg_slice.sv
axi3_slr_crossing.sv
tb_axi3_slr_crossing.sv

//--- tb_axi3_slr_crossing.sv
`default_nettype none

// Drives one channel through the DUT and scores what leaves the far end
module channel_traffic #(
    parameter type   PAYLOAD_T    = logic,
    parameter string NAME         = "",
    parameter int    SEED_OFFSET  = 0,
    parameter int    STREAM_BEATS = 32,
    parameter int    RANDOM_BEATS = 200
) (
    input  logic     aclk,
    input  logic     reset,
    output logic     in_valid,
    input  logic     in_ready,
    output PAYLOAD_T in_data,
    input  logic     out_valid,
    output logic     out_ready,
    input  PAYLOAD_T out_data,
    output int       errors,
    output logic     done,
    output logic     balanced
);

    PAYLOAD_T    exp_q [$];
    PAYLOAD_T    exp_data;
    logic        have_exp;
    logic        in_fire;
    logic        out_fire;
    logic        streaming;
    int          in_count;
    int          out_count;
    logic [31:0] state;
    logic [95:0] word;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    assign streaming = out_count < STREAM_BEATS;  // Ready stays high until the burst has drained

    initial begin
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        in_fire   = 1'b0;
        have_exp  = 1'b0;
        exp_data  = '0;
        errors    = 0;
        in_count  = 0;
        out_count = 0;
        state     = 32'd90428 + SEED_OFFSET;
        wait (!reset);
        forever begin
            @(posedge aclk);
            #1;
            state     = xorshift(state);
            out_ready = streaming || state[2];
            if (in_fire) begin
                in_valid = 1'b0;  // Beat was taken at this edge
            end
            if (!in_valid && (streaming || state[1:0] != 2'b00)
                    && in_count < (streaming ? STREAM_BEATS : STREAM_BEATS + RANDOM_BEATS)) begin
                for (int i = 0; i < 3; i++) begin
                    state            = xorshift(state);
                    word[i*32 +: 32] = state;
                end
                in_valid = 1'b1;
                in_data  = word[$bits(PAYLOAD_T)-1:0];
            end
        end
    end

    // Nothing moves between the falling edge and the next rising edge
    always @(negedge aclk) begin
        in_fire  = in_valid && in_ready;
        out_fire = out_valid && out_ready;
        if (out_fire) begin
            have_exp = exp_q.size() != 0;
            if (have_exp) begin
                exp_data = exp_q.pop_front();
            end
            out_count++;
        end
        if (in_fire) begin
            exp_q.push_back(in_data);
            in_count++;
        end
        done     = out_count >= STREAM_BEATS + RANDOM_BEATS;
        balanced = (in_count == out_count) && (exp_q.size() == 0);
    end

    assert property (@(posedge aclk) out_valid && out_ready |-> have_exp)
        else log_error($sformatf("Channel %s delivered a beat that was never sent", NAME));

    assert property (@(posedge aclk) out_valid && out_ready && have_exp |-> out_data == exp_data)
        else log_error($sformatf("Mismatch at %0t on channel %s: got %h, expected %h",
                                 $time, NAME, $sampled(out_data), $sampled(exp_data)));

    assert property (@(posedge aclk) disable iff (reset)
            out_valid && !out_ready |=> out_valid && $stable(out_data))
        else log_error($sformatf("Mismatch at %0t on channel %s: stalled beat changed",
                                 $time, NAME));

    assert property (@(posedge aclk) out_count inside {[1:STREAM_BEATS-1]} |-> out_valid)
        else log_error($sformatf("Channel %s left a gap in the back-to-back burst", NAME));

endmodule : channel_traffic

module tb_axi3_slr_crossing;

    import axi3_slice_pkg::*;

    localparam int NUM_SLICES  = 2;
    localparam int BEATS       = 232;  // 32 back-to-back plus 200 with random back-pressure
    localparam int CYCLE_LIMIT = 5 * (BEATS + 50);

    logic       aclk, reset, m_reset;
    logic       s_aw_valid, s_aw_ready, m_aw_valid, m_aw_ready;
    logic       s_w_valid, s_w_ready, m_w_valid, m_w_ready;
    logic       s_b_valid, s_b_ready, m_b_valid, m_b_ready;
    logic       s_ar_valid, s_ar_ready, m_ar_valid, m_ar_ready;
    logic       s_r_valid, s_r_ready, m_r_valid, m_r_ready;
    addr_chan_t s_aw_data, m_aw_data, s_ar_data, m_ar_data;
    w_chan_t    s_w_data, m_w_data;
    b_chan_t    s_b_data, m_b_data;
    r_chan_t    s_r_data, m_r_data;
    int         errors [5];
    logic [4:0] done, balanced;
    int         top_errors;
    int         cycles;
    int         reset_edges;

    axi3_slr_crossing #(.NUM_SLICES(NUM_SLICES), .MODE(SLICE_FULL)) i_dut (.*);

    channel_traffic #(.PAYLOAD_T(addr_chan_t), .NAME("AW"), .SEED_OFFSET(0)) i_aw_traffic (
        .aclk, .reset, .in_valid(s_aw_valid), .in_ready(s_aw_ready), .in_data(s_aw_data),
        .out_valid(m_aw_valid), .out_ready(m_aw_ready), .out_data(m_aw_data),
        .errors(errors[0]), .done(done[0]), .balanced(balanced[0]));
    channel_traffic #(.PAYLOAD_T(w_chan_t), .NAME("W"), .SEED_OFFSET(1)) i_w_traffic (
        .aclk, .reset, .in_valid(s_w_valid), .in_ready(s_w_ready), .in_data(s_w_data),
        .out_valid(m_w_valid), .out_ready(m_w_ready), .out_data(m_w_data),
        .errors(errors[1]), .done(done[1]), .balanced(balanced[1]));
    // Responses enter on the peripheral side
    channel_traffic #(.PAYLOAD_T(b_chan_t), .NAME("B"), .SEED_OFFSET(2)) i_b_traffic (
        .aclk, .reset, .in_valid(m_b_valid), .in_ready(m_b_ready), .in_data(m_b_data),
        .out_valid(s_b_valid), .out_ready(s_b_ready), .out_data(s_b_data),
        .errors(errors[2]), .done(done[2]), .balanced(balanced[2]));
    channel_traffic #(.PAYLOAD_T(addr_chan_t), .NAME("AR"), .SEED_OFFSET(3)) i_ar_traffic (
        .aclk, .reset, .in_valid(s_ar_valid), .in_ready(s_ar_ready), .in_data(s_ar_data),
        .out_valid(m_ar_valid), .out_ready(m_ar_ready), .out_data(m_ar_data),
        .errors(errors[3]), .done(done[3]), .balanced(balanced[3]));
    channel_traffic #(.PAYLOAD_T(r_chan_t), .NAME("R"), .SEED_OFFSET(4)) i_r_traffic (
        .aclk, .reset, .in_valid(m_r_valid), .in_ready(m_r_ready), .in_data(m_r_data),
        .out_valid(s_r_valid), .out_ready(s_r_ready), .out_data(s_r_data),
        .errors(errors[4]), .done(done[4]), .balanced(balanced[4]));

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        if (reset) begin
            reset_edges <= reset_edges + 1;
        end
    end

    function automatic int traffic_errors();
        int sum;
        sum = 0;
        for (int c = 0; c < 5; c++) begin
            sum += errors[c];
        end
        return sum;
    endfunction

    // Each full-mode slice holds the peripheral reset one cycle longer
    assert property (@(posedge aclk) $fell(reset) |-> m_reset [*NUM_SLICES] ##1 !m_reset)
        else begin
            top_errors++;
            $display("m_reset did not fall %0d cycles after reset", NUM_SLICES);
        end

    // The last slice sees reset only after it has passed every earlier stage
    assert property (@(posedge aclk)
            reset_edges >= NUM_SLICES && (reset || $past(reset))
            |-> !(m_aw_valid || m_w_valid || s_b_valid || m_ar_valid || s_r_valid))
        else begin
            top_errors++;
            $display("An output valid was high in or just after reset");
        end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles with beats still in flight", CYCLE_LIMIT);
        $display("Errors: %0d during traffic, %0d at top level", traffic_errors(), top_errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        aclk        = 1'b0;
        reset       = 1'b1;
        top_errors  = 0;
        reset_edges = 0;
        repeat (5) @(posedge aclk);
        #1;
        reset = 1'b0;
        wait (&done);
        repeat (4) @(posedge aclk);  // A duplicated beat would arrive in this window
        assert (&balanced)
            else begin
                top_errors++;
                $display("Beats were lost, duplicated or left queued, balance %b", balanced);
            end
        $display("Errors: %0d during traffic, %0d at top level", traffic_errors(), top_errors);
        if (traffic_errors() + top_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_axi3_slr_crossing

`default_nettype wire

//--- axi3_slr_crossing.sv
`default_nettype none

`include "axi3_slice_macros.svh"

module axi3_slr_crossing #(
    parameter int                          NUM_SLICES = `AXI3_NUM_SLICES,
    parameter axi3_slice_pkg::slice_mode_t MODE       = axi3_slice_pkg::SLICE_FULL
) (
    input  logic                       aclk,
    input  logic                       reset,
    output logic                       m_reset,
    input  logic                       s_aw_valid,
    output logic                       s_aw_ready,
    input  axi3_slice_pkg::addr_chan_t s_aw_data,
    input  logic                       s_w_valid,
    output logic                       s_w_ready,
    input  axi3_slice_pkg::w_chan_t    s_w_data,
    output logic                       s_b_valid,
    input  logic                       s_b_ready,
    output axi3_slice_pkg::b_chan_t    s_b_data,
    input  logic                       s_ar_valid,
    output logic                       s_ar_ready,
    input  axi3_slice_pkg::addr_chan_t s_ar_data,
    output logic                       s_r_valid,
    input  logic                       s_r_ready,
    output axi3_slice_pkg::r_chan_t    s_r_data,
    output logic                       m_aw_valid,
    input  logic                       m_aw_ready,
    output axi3_slice_pkg::addr_chan_t m_aw_data,
    output logic                       m_w_valid,
    input  logic                       m_w_ready,
    output axi3_slice_pkg::w_chan_t    m_w_data,
    input  logic                       m_b_valid,
    output logic                       m_b_ready,
    input  axi3_slice_pkg::b_chan_t    m_b_data,
    output logic                       m_ar_valid,
    input  logic                       m_ar_ready,
    output axi3_slice_pkg::addr_chan_t m_ar_data,
    input  logic                       m_r_valid,
    output logic                       m_r_ready,
    input  axi3_slice_pkg::r_chan_t    m_r_data
);

    import axi3_slice_pkg::*;

    // Index 0 is the controller end and index NUM_SLICES the peripheral end
    logic [NUM_SLICES:0] rst;
    logic [NUM_SLICES:0] aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic [NUM_SLICES:0] ar_valid, ar_ready, r_valid, r_ready;
    addr_chan_t          aw_data [NUM_SLICES+1];
    w_chan_t             w_data  [NUM_SLICES+1];
    b_chan_t             b_data  [NUM_SLICES+1];
    addr_chan_t          ar_data [NUM_SLICES+1];
    r_chan_t             r_data  [NUM_SLICES+1];

    assign rst[0]      = reset;
    assign aw_valid[0] = s_aw_valid;
    assign s_aw_ready  = aw_ready[0];
    assign aw_data[0]  = s_aw_data;
    assign w_valid[0]  = s_w_valid;
    assign s_w_ready   = w_ready[0];
    assign w_data[0]   = s_w_data;
    assign s_b_valid   = b_valid[0];
    assign b_ready[0]  = s_b_ready;
    assign s_b_data    = b_data[0];
    assign ar_valid[0] = s_ar_valid;
    assign s_ar_ready  = ar_ready[0];
    assign ar_data[0]  = s_ar_data;
    assign s_r_valid   = r_valid[0];
    assign r_ready[0]  = s_r_ready;
    assign s_r_data    = r_data[0];

    assign m_reset              = rst[NUM_SLICES];
    assign m_aw_valid           = aw_valid[NUM_SLICES];
    assign aw_ready[NUM_SLICES] = m_aw_ready;
    assign m_aw_data            = aw_data[NUM_SLICES];
    assign m_w_valid            = w_valid[NUM_SLICES];
    assign w_ready[NUM_SLICES]  = m_w_ready;
    assign m_w_data             = w_data[NUM_SLICES];
    assign b_valid[NUM_SLICES]  = m_b_valid;
    assign m_b_ready            = b_ready[NUM_SLICES];
    assign b_data[NUM_SLICES]   = m_b_data;
    assign m_ar_valid           = ar_valid[NUM_SLICES];
    assign ar_ready[NUM_SLICES] = m_ar_ready;
    assign m_ar_data            = ar_data[NUM_SLICES];
    assign r_valid[NUM_SLICES]  = m_r_valid;
    assign m_r_ready            = r_ready[NUM_SLICES];
    assign r_data[NUM_SLICES]   = m_r_data;

    generate
        for (genvar k = 0; k < NUM_SLICES; k++) begin : g_slice
            axi3_reg_slice #(.MODE(MODE)) i_reg_slice (
                .aclk,
                .reset     (rst[k]),  // Each stage leaves reset behind its neighbour
                .m_reset   (rst[k+1]),
                .s_aw_valid(aw_valid[k]),   .s_aw_ready(aw_ready[k]),   .s_aw_data(aw_data[k]),
                .s_w_valid (w_valid[k]),    .s_w_ready (w_ready[k]),    .s_w_data (w_data[k]),
                .s_b_valid (b_valid[k]),    .s_b_ready (b_ready[k]),    .s_b_data (b_data[k]),
                .s_ar_valid(ar_valid[k]),   .s_ar_ready(ar_ready[k]),   .s_ar_data(ar_data[k]),
                .s_r_valid (r_valid[k]),    .s_r_ready (r_ready[k]),    .s_r_data (r_data[k]),
                .m_aw_valid(aw_valid[k+1]), .m_aw_ready(aw_ready[k+1]), .m_aw_data(aw_data[k+1]),
                .m_w_valid (w_valid[k+1]),  .m_w_ready (w_ready[k+1]),  .m_w_data (w_data[k+1]),
                .m_b_valid (b_valid[k+1]),  .m_b_ready (b_ready[k+1]),  .m_b_data (b_data[k+1]),
                .m_ar_valid(ar_valid[k+1]), .m_ar_ready(ar_ready[k+1]), .m_ar_data(ar_data[k+1]),
                .m_r_valid (r_valid[k+1]),  .m_r_ready (r_ready[k+1]),  .m_r_data (r_data[k+1])
            );
        end
    endgenerate

endmodule : axi3_slr_crossing

`default_nettype wire

//--- axi3_reg_slice.sv
`default_nettype none

module axi3_reg_slice #(
    parameter axi3_slice_pkg::slice_mode_t MODE = axi3_slice_pkg::SLICE_FULL
) (
    input  logic                       aclk,
    input  logic                       reset,
    output logic                       m_reset,
    input  logic                       s_aw_valid,
    output logic                       s_aw_ready,
    input  axi3_slice_pkg::addr_chan_t s_aw_data,
    input  logic                       s_w_valid,
    output logic                       s_w_ready,
    input  axi3_slice_pkg::w_chan_t    s_w_data,
    output logic                       s_b_valid,
    input  logic                       s_b_ready,
    output axi3_slice_pkg::b_chan_t    s_b_data,
    input  logic                       s_ar_valid,
    output logic                       s_ar_ready,
    input  axi3_slice_pkg::addr_chan_t s_ar_data,
    output logic                       s_r_valid,
    input  logic                       s_r_ready,
    output axi3_slice_pkg::r_chan_t    s_r_data,
    output logic                       m_aw_valid,
    input  logic                       m_aw_ready,
    output axi3_slice_pkg::addr_chan_t m_aw_data,
    output logic                       m_w_valid,
    input  logic                       m_w_ready,
    output axi3_slice_pkg::w_chan_t    m_w_data,
    input  logic                       m_b_valid,
    output logic                       m_b_ready,
    input  axi3_slice_pkg::b_chan_t    m_b_data,
    output logic                       m_ar_valid,
    input  logic                       m_ar_ready,
    output axi3_slice_pkg::addr_chan_t m_ar_data,
    input  logic                       m_r_valid,
    output logic                       m_r_ready,
    input  axi3_slice_pkg::r_chan_t    m_r_data
);

    import axi3_slice_pkg::*;

    axi_channel_slice #(.PAYLOAD_T(addr_chan_t), .MODE(MODE)) i_aw_slice (
        .aclk, .reset,
        .s_valid(s_aw_valid), .s_ready(s_aw_ready), .s_data(s_aw_data),
        .m_valid(m_aw_valid), .m_ready(m_aw_ready), .m_data(m_aw_data)
    );

    axi_channel_slice #(.PAYLOAD_T(w_chan_t), .MODE(MODE)) i_w_slice (
        .aclk, .reset,
        .s_valid(s_w_valid), .s_ready(s_w_ready), .s_data(s_w_data),
        .m_valid(m_w_valid), .m_ready(m_w_ready), .m_data(m_w_data)
    );

    // Response channels flow from the peripheral back to the controller
    axi_channel_slice #(.PAYLOAD_T(b_chan_t), .MODE(MODE)) i_b_slice (
        .aclk, .reset,
        .s_valid(m_b_valid), .s_ready(m_b_ready), .s_data(m_b_data),
        .m_valid(s_b_valid), .m_ready(s_b_ready), .m_data(s_b_data)
    );

    axi_channel_slice #(.PAYLOAD_T(addr_chan_t), .MODE(MODE)) i_ar_slice (
        .aclk, .reset,
        .s_valid(s_ar_valid), .s_ready(s_ar_ready), .s_data(s_ar_data),
        .m_valid(m_ar_valid), .m_ready(m_ar_ready), .m_data(m_ar_data)
    );

    axi_channel_slice #(.PAYLOAD_T(r_chan_t), .MODE(MODE)) i_r_slice (
        .aclk, .reset,
        .s_valid(m_r_valid), .s_ready(m_r_ready), .s_data(m_r_data),
        .m_valid(s_r_valid), .m_ready(s_r_ready), .m_data(s_r_data)
    );

    reset_pipe #(.STAGES(reset_stages(MODE))) i_reset_pipe (
        .aclk,
        .reset,
        .reset_out(m_reset)
    );

endmodule : axi3_reg_slice

`default_nettype wire

//--- reset_pipe.sv
`default_nettype none

module reset_pipe #(
    parameter int STAGES = 1
) (
    input  logic aclk,
    input  logic reset,
    output logic reset_out
);

    generate
        if (STAGES == 0) begin : g_wire
            assign reset_out = reset;
        end else begin : g_pipe
            logic pipe [STAGES];

            always_ff @(posedge aclk) begin
                pipe[0] <= reset;
                for (int i = 1; i < STAGES; i++) begin
                    pipe[i] <= pipe[i-1];
                end
            end

            assign reset_out = pipe[STAGES-1];
        end
    endgenerate

endmodule : reset_pipe

`default_nettype wire

//--- axi_channel_slice.sv
`default_nettype none

module axi_channel_slice #(
    parameter type                         PAYLOAD_T = logic,
    parameter axi3_slice_pkg::slice_mode_t MODE      = axi3_slice_pkg::SLICE_FULL
) (
    input  logic     aclk,
    input  logic     reset,
    input  logic     s_valid,
    output logic     s_ready,
    input  PAYLOAD_T s_data,
    output logic     m_valid,
    input  logic     m_ready,
    output PAYLOAD_T m_data
);

    import axi3_slice_pkg::*;

    generate
        if (MODE == SLICE_FULL) begin : g_full
            logic     main_valid;
            logic     skid_valid;
            logic     main_load;
            PAYLOAD_T main_data;
            PAYLOAD_T skid_data;

            assign main_load = !main_valid || m_ready;  // Output entry is free this cycle

            // Ready is its own flop and tracks an empty skid entry outside reset
            always_ff @(posedge aclk) begin
                if (reset) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                    s_ready    <= 1'b0;
                end else if (main_load) begin
                    main_valid <= skid_valid || (s_valid && s_ready);
                    skid_valid <= 1'b0;
                    s_ready    <= 1'b1;
                end else if (s_valid && s_ready) begin
                    skid_valid <= 1'b1;  // Output stalled so the beat parks here
                    s_ready    <= 1'b0;
                end
            end

            always_ff @(posedge aclk) begin
                if (main_load) begin
                    main_data <= skid_valid ? skid_data : s_data;
                end
                if (!main_load && s_ready) begin
                    skid_data <= s_data;
                end
            end

            assign m_valid = main_valid;
            assign m_data  = main_data;

            // A slice holding two beats takes no third one
            assert property (@(posedge aclk) disable iff (reset)
                main_valid && skid_valid |-> !(s_valid && s_ready));
        end else if (MODE == SLICE_FORWARD) begin : g_forward
            logic     main_valid;
            PAYLOAD_T main_data;

            assign s_ready = !main_valid || m_ready;

            always_ff @(posedge aclk) begin
                if (reset) begin
                    main_valid <= 1'b0;
                end else if (s_ready) begin
                    main_valid <= s_valid;
                end
            end

            always_ff @(posedge aclk) begin
                if (s_ready) begin
                    main_data <= s_data;
                end
            end

            assign m_valid = main_valid;
            assign m_data  = main_data;
        end else if (MODE == SLICE_REVERSE) begin : g_reverse
            logic     skid_valid;
            PAYLOAD_T skid_data;

            always_ff @(posedge aclk) begin
                if (reset) begin
                    skid_valid <= 1'b0;
                end else if (skid_valid) begin
                    skid_valid <= !m_ready;
                end else begin
                    skid_valid <= s_valid && !m_ready;  // Catch the beat the output refused
                end
            end

            always_ff @(posedge aclk) begin
                if (!skid_valid) begin
                    skid_data <= s_data;
                end
            end

            assign s_ready = !skid_valid;
            assign m_valid = skid_valid || s_valid;
            assign m_data  = skid_valid ? skid_data : s_data;
        end else begin : g_bypass
            assign s_ready = m_ready;
            assign m_valid = s_valid;
            assign m_data  = s_data;
        end
    endgenerate

    // An offered output beat holds steady until it is taken
    assert property (@(posedge aclk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule : axi_channel_slice

`default_nettype wire

//--- axi3_slice_pkg.sv
`default_nettype none

`include "axi3_slice_macros.svh"

package axi3_slice_pkg;

    typedef enum logic [1:0] {
        SLICE_BYPASS,
        SLICE_FORWARD,
        SLICE_REVERSE,
        SLICE_FULL
    } slice_mode_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]   id;
        logic [`AXI3_ADDR_WID-1:0] addr;
        logic [3:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic [1:0]                lock;  // AXI3 keeps the two-bit lock field
        logic [3:0]                cache;
        logic [2:0]                prot;
        logic [3:0]                qos;
        logic [3:0]                region;
        logic [`AXI3_USER_WID-1:0] user;
    } addr_chan_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]        id;  // Write interleaving ID
        logic [`AXI3_DATA_WID-1:0]      data;
        logic [`AXI3_DATA_BYTE_WID-1:0] strb;
        logic                           last;
        logic [`AXI3_USER_WID-1:0]      user;
    } w_chan_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]   id;
        logic [1:0]                resp;
        logic [`AXI3_USER_WID-1:0] user;
    } b_chan_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]   id;
        logic [`AXI3_DATA_WID-1:0] data;
        logic [1:0]                resp;
        logic                      last;
        logic [`AXI3_USER_WID-1:0] user;
    } r_chan_t;

    // Registered modes add a cycle, so the peripheral reset lags by one
    function automatic int reset_stages(input slice_mode_t mode);
        case (mode)
            SLICE_FORWARD,
            SLICE_FULL : return 1;
            default    : return 0;
        endcase
    endfunction

endpackage : axi3_slice_pkg

`default_nettype wire

//--- axi3_slice_macros.svh
`ifndef AXI3_SLICE_MACROS_SVH
`define AXI3_SLICE_MACROS_SVH

// AXI3 bus widths shared by every slice
`define AXI3_ADDR_WID      32
`define AXI3_DATA_BYTE_WID 4
`define AXI3_ID_WID        4
`define AXI3_USER_WID      2

`define AXI3_DATA_WID      (`AXI3_DATA_BYTE_WID * 8)

// Number of register slices in series across the crossing
`define AXI3_NUM_SLICES    2

`endif
